//--- common/monopixPkg.sv
package monopixPkg;

    // Array geometry
    localparam int NUM_FLAVORS   = 4;
    localparam int NUM_COLS      = 8;
    localparam int COL_ADDR_BITS = 3;

    // Time stamp and readout word
    localparam int BCID_BITS     = 6;
    localparam int HIT_WORD_BITS = COL_ADDR_BITS + BCID_BITS;  // Column address on top

    localparam logic [HIT_WORD_BITS-1:0] TEST_PATTERN = 9'h1A5;

    // Front-end flavors, also the index into every per-flavor vector
    typedef enum logic [1:0] {
        PMOS     = 2'd0,
        PMOS_DPW = 2'd1,
        COMP     = 2'd2,
        HV       = 2'd3
    } flavorE;

    // Global configuration word, shifted in MSB first
    typedef struct packed {
        logic [NUM_FLAVORS-1:0]          EnFlavor;
        logic [NUM_FLAVORS-1:0]          EnTestPattern;
        logic [NUM_FLAVORS-1:0]          EnOut;
        logic [NUM_FLAVORS-1:0]          EnHitOr;
        logic [NUM_FLAVORS*NUM_COLS-1:0] ColMask;      // 8 per flavor, flavor 0 lowest
        logic [NUM_COLS-1:0]             ColPulseSel;  // Shared by all flavors
    } confT;

    localparam int CONF_BITS = $bits(confT);

    // All flavors on, every column enabled, no injection
    localparam confT DEFAULT_CONF = '{
        EnFlavor:      4'hF,
        EnTestPattern: 4'h0,
        EnOut:         4'hF,
        EnHitOr:       4'hF,
        ColMask:       32'hFFFF_FFFF,
        ColPulseSel:   8'h00
    };

endpackage

//--- common/colBusIf.sv
interface colBusIf;

    logic                                                     Frozen;    // Registered Freeze
    logic [monopixPkg::NUM_COLS-1:0]                          ClearCol;  // One-hot, one cycle
    logic [monopixPkg::NUM_COLS-1:0]                          ColFull;
    logic [monopixPkg::NUM_COLS-1:0][monopixPkg::BCID_BITS-1:0] ColBcid;

    // Column side stores hits and reports them
    modport cols (
        input  Frozen,
        input  ClearCol,
        output ColFull,
        output ColBcid
    );

    // Readout side freezes and empties columns
    modport reader (
        output Frozen,
        output ClearCol,
        input  ColFull,
        input  ColBcid
    );

endinterface

//--- design/confShiftReg.sv
module confShiftReg (
    input  logic              ClkBx,
    input  logic              reset_ff,
    input  logic              DefConf,
    input  logic              ConfShift,
    input  logic              ConfSi,
    input  logic              ConfLoad,
    output logic              ConfSo,
    output monopixPkg::confT  Conf
);

    localparam int MSB = monopixPkg::CONF_BITS - 1;

    logic [MSB:0] shadowReg;

    // Shadow chain, new bits enter at the LSB
    always_ff @(posedge ClkBx) begin
        if (reset_ff || DefConf) begin
            shadowReg <= monopixPkg::DEFAULT_CONF;
        end else if (ConfShift) begin
            shadowReg <= {shadowReg[MSB-1:0], ConfSi};
        end
    end

    // Active copy only changes on a load strobe
    always_ff @(posedge ClkBx) begin
        if (reset_ff || DefConf) begin
            Conf <= monopixPkg::DEFAULT_CONF;
        end else if (ConfLoad) begin
            Conf <= monopixPkg::confT'(shadowReg);  // Value before any shift at this edge
        end
    end

    assign ConfSo = shadowReg[MSB];

endmodule

//--- design/bcidCounter.sv
module bcidCounter (
    input  logic                             ClkBx,
    input  logic                             reset_ff,
    input  logic                             ResetBcid,
    output logic [monopixPkg::BCID_BITS-1:0] Bcid
);

    logic [monopixPkg::BCID_BITS-1:0] binCount;

    // Free running, wraps naturally at the counter width
    always_ff @(posedge ClkBx) begin
        if (reset_ff || ResetBcid) begin
            binCount <= '0;
        end else begin
            binCount <= binCount + 1'b1;
        end
    end

    // Gray code, one bit flips per crossing
    assign Bcid = binCount ^ (binCount >> 1);

endmodule

//--- readout/pixelColumns.sv
module pixelColumns (
    input  logic                             ClkBx,
    input  logic                             reset_ff,
    input  logic [monopixPkg::NUM_COLS-1:0]  Hit,
    input  logic                             Pulse,
    input  logic [monopixPkg::NUM_COLS-1:0]  ColPulseSel,
    input  logic [monopixPkg::NUM_COLS-1:0]  ColMask,
    input  logic                             EnFlavor,
    input  logic                             EnHitOr,
    input  logic [monopixPkg::BCID_BITS-1:0] Bcid,
    output logic                             HitOr,
    colBusIf.cols                            Bus
);

    localparam int NC = monopixPkg::NUM_COLS;

    logic [NC-1:0]                              hitIn;
    logic [NC-1:0]                              capture;
    logic [NC-1:0]                              colFull;
    logic [NC-1:0][monopixPkg::BCID_BITS-1:0]   colBcid;

    // Discriminator hits plus injection, then masking
    assign hitIn = (Hit | ({NC{Pulse}} & ColPulseSel)) & ColMask & {NC{EnFlavor}};

    // Empty columns only, and never while frozen
    assign capture = hitIn & ~colFull & {NC{~Bus.Frozen}};

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            colFull <= '0;
        end else begin
            // Clear hits only full columns, capture only empty ones
            colFull <= (colFull & ~Bus.ClearCol) | capture;
        end
    end

    // Time stamp slots
    always_ff @(posedge ClkBx) begin
        for (int c = 0; c < NC; c++) begin
            if (capture[c]) begin
                colBcid[c] <= Bcid;
            end
        end
    end

    // Fast OR of this flavor, independent of freeze
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            HitOr <= 1'b0;
        end else begin
            HitOr <= EnHitOr & (|hitIn);
        end
    end

    assign Bus.ColFull = colFull;
    assign Bus.ColBcid = colBcid;

endmodule

//--- readout/tokenReadout.sv
module tokenReadout (
    input  logic                                 ClkBx,
    input  logic                                 reset_ff,
    input  logic                                 Freeze,
    input  logic                                 Read,
    input  logic                                 EnFlavor,
    input  logic                                 EnOut,
    input  logic                                 EnTestPattern,
    output logic                                 Token,
    output logic                                 DataValid,
    output logic [monopixPkg::HIT_WORD_BITS-1:0] DataOut,
    colBusIf.reader                              Bus
);

    localparam int NC = monopixPkg::NUM_COLS;
    localparam int AW = monopixPkg::COL_ADDR_BITS;

    logic          frozen;
    logic          anyFull;
    logic          readAccept;
    logic          readHit;
    logic [AW-1:0] lowCol;
    logic [NC-1:0] lowOneHot;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            frozen <= 1'b0;
        end else begin
            frozen <= Freeze;
        end
    end

    assign anyFull = |Bus.ColFull;

    // Token sees the column state before this edge's clear
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            Token <= 1'b0;
        end else begin
            Token <= frozen & anyFull & EnFlavor & EnOut;
        end
    end

    // Lowest full column wins
    always_comb begin
        lowCol = '0;
        for (int c = NC - 1; c >= 0; c--) begin
            if (Bus.ColFull[c]) begin
                lowCol = AW'(c);
            end
        end
    end

    assign lowOneHot = NC'(1) << lowCol;

    // Late read after the last word finds nothing and is dropped
    assign readAccept = Read & Token & (anyFull | EnTestPattern);
    assign readHit    = readAccept & ~EnTestPattern;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            DataValid <= 1'b0;
        end else begin
            DataValid <= readAccept;
        end
    end

    // Word held until the next accepted read
    always_ff @(posedge ClkBx) begin
        if (readAccept) begin
            if (EnTestPattern) begin
                DataOut <= monopixPkg::TEST_PATTERN;
            end else begin
                DataOut <= {lowCol, Bus.ColBcid[lowCol]};
            end
        end
    end

    assign Bus.Frozen   = frozen;
    assign Bus.ClearCol = readHit ? lowOneHot : '0;  // Test pattern keeps hits

endmodule

//--- design/monopixTop.sv
module monopixTop (
    input  logic                                                            ClkBx,
    input  logic                                                            reset_ff,
    input  logic                                                            DefConf,
    input  logic                                                            ConfShift,
    input  logic                                                            ConfSi,
    input  logic                                                            ConfLoad,
    input  logic                                                            ResetBcid,
    input  logic                                                            Pulse,
    input  logic [monopixPkg::NUM_FLAVORS-1:0][monopixPkg::NUM_COLS-1:0]    Hit,
    input  logic [monopixPkg::NUM_FLAVORS-1:0]                              Freeze,
    input  logic [monopixPkg::NUM_FLAVORS-1:0]                              Read,
    output logic                                                            ConfSo,
    output logic [monopixPkg::NUM_FLAVORS-1:0]                              Token,
    output logic [monopixPkg::NUM_FLAVORS-1:0]                              DataValid,
    output logic [monopixPkg::NUM_FLAVORS-1:0][monopixPkg::HIT_WORD_BITS-1:0] DataOut,
    output logic [monopixPkg::NUM_FLAVORS-1:0]                              HitOr
);

    localparam int NC = monopixPkg::NUM_COLS;

    monopixPkg::confT                 conf;
    logic [monopixPkg::BCID_BITS-1:0] bcidGray;

    confShiftReg uConf (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .DefConf   (DefConf),
        .ConfShift (ConfShift),
        .ConfSi    (ConfSi),
        .ConfLoad  (ConfLoad),
        .ConfSo    (ConfSo),
        .Conf      (conf)
    );

    bcidCounter uBcid (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .ResetBcid (ResetBcid),
        .Bcid      (bcidGray)
    );

    for (genvar f = 0; f < monopixPkg::NUM_FLAVORS; f++) begin : gFlavor
        localparam monopixPkg::flavorE FLAVOR = monopixPkg::flavorE'(f);

        colBusIf colBus ();

        pixelColumns uCols (
            .ClkBx       (ClkBx),
            .reset_ff    (reset_ff),
            .Hit         (Hit[FLAVOR]),
            .Pulse       (Pulse),
            .ColPulseSel (conf.ColPulseSel),
            .ColMask     (conf.ColMask[NC*FLAVOR +: NC]),  // This flavor's mask byte
            .EnFlavor    (conf.EnFlavor[FLAVOR]),
            .EnHitOr     (conf.EnHitOr[FLAVOR]),
            .Bcid        (bcidGray),
            .HitOr       (HitOr[FLAVOR]),
            .Bus         (colBus.cols)
        );

        tokenReadout uReadout (
            .ClkBx         (ClkBx),
            .reset_ff      (reset_ff),
            .Freeze        (Freeze[FLAVOR]),
            .Read          (Read[FLAVOR]),
            .EnFlavor      (conf.EnFlavor[FLAVOR]),
            .EnOut         (conf.EnOut[FLAVOR]),
            .EnTestPattern (conf.EnTestPattern[FLAVOR]),
            .Token         (Token[FLAVOR]),
            .DataValid     (DataValid[FLAVOR]),
            .DataOut       (DataOut[FLAVOR]),
            .Bus           (colBus.reader)
        );
    end

endmodule

//--- verif/tbMonopix.sv
module tbMonopix;

    localparam int NF      = monopixPkg::NUM_FLAVORS;
    localparam int NC      = monopixPkg::NUM_COLS;
    localparam int AW      = monopixPkg::COL_ADDR_BITS;
    localparam int BB      = monopixPkg::BCID_BITS;
    localparam int WB      = monopixPkg::HIT_WORD_BITS;
    localparam int CB      = monopixPkg::CONF_BITS;
    localparam int DPW     = int'(monopixPkg::PMOS_DPW);
    localparam int COMPF   = int'(monopixPkg::COMP);
    localparam int TIMEOUT = 200;

    logic                   ClkBx;
    logic                   reset_ff;
    logic                   DefConf;
    logic                   ConfShift;
    logic                   ConfSi;
    logic                   ConfLoad;
    logic                   ResetBcid;
    logic                   Pulse;
    logic [NF-1:0][NC-1:0]  Hit;
    logic [NF-1:0]          Freeze;
    logic [NF-1:0]          Read;
    logic                   ConfSo;
    logic [NF-1:0]          Token;
    logic [NF-1:0]          DataValid;
    logic [NF-1:0][WB-1:0]  DataOut;
    logic [NF-1:0]          HitOr;

    // Reference model state
    logic [CB-1:0]                 refShadow;
    monopixPkg::confT              activeConf;
    logic [BB-1:0]                 refBin;
    logic [NF-1:0]                 refFrozen;
    logic [NF-1:0][NC-1:0]         refFull;
    logic [NF-1:0][NC-1:0][BB-1:0] refBcid;
    logic [NF-1:0]                 expToken;
    logic [NF-1:0]                 expValid;
    logic [NF-1:0]                 expHitOr;
    logic [NF-1:0][WB-1:0]         expWord;
    logic [NF-1:0]                 wordSeen;  // Flavor has returned at least one word

    int     errors = 0;
    int     propErrors = 0;
    int     timeouts = 0;
    integer seed = 12;

    monopixTop UUT (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .DefConf   (DefConf),
        .ConfShift (ConfShift),
        .ConfSi    (ConfSi),
        .ConfLoad  (ConfLoad),
        .ResetBcid (ResetBcid),
        .Pulse     (Pulse),
        .Hit       (Hit),
        .Freeze    (Freeze),
        .Read      (Read),
        .ConfSo    (ConfSo),
        .Token     (Token),
        .DataValid (DataValid),
        .DataOut   (DataOut),
        .HitOr     (HitOr)
    );

    initial begin
        ClkBx = 1'b0;
        forever #5 ClkBx = ~ClkBx;
    end

    // A word only ever follows a cycle with the token up
    assert property (@(posedge ClkBx) disable iff (reset_ff) (DataValid & ~$past(Token)) == '0)
        else begin
            propErrors++;
            $display("Error at %0t: DataValid without Token in the previous cycle", $time);
        end

    task automatic reportMismatch(input string what, input logic [CB-1:0] got,
                                  input logic [CB-1:0] exp);
        errors++;
        $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic compareOutputs();
        assert (Token === expToken) else reportMismatch("Token", CB'(Token), CB'(expToken));
        assert (DataValid === expValid)
            else reportMismatch("DataValid", CB'(DataValid), CB'(expValid));
        assert (HitOr === expHitOr) else reportMismatch("HitOr", CB'(HitOr), CB'(expHitOr));
        assert (ConfSo === refShadow[CB-1])
            else reportMismatch("ConfSo", CB'(ConfSo), CB'(refShadow[CB-1]));
        for (int f = 0; f < NF; f++) begin
            if (wordSeen[f]) begin  // Last word holds between reads
                assert (DataOut[f] === expWord[f])
                    else reportMismatch("DataOut", CB'(DataOut[f]), CB'(expWord[f]));
            end
        end
    endtask

    // Model takes this cycle's inputs and outputs are checked at the falling edge
    task automatic tick();
        logic [NC-1:0] fullBefore;
        logic [NC-1:0] hitIn;
        logic [NC-1:0] clearCol;
        logic [BB-1:0] grayNow;
        bit            found;
        grayNow  = refBin ^ (refBin >> 1);
        expValid = '0;
        for (int f = 0; f < NF; f++) begin
            fullBefore = refFull[f];
            hitIn = (Hit[f] | ({NC{Pulse}} & activeConf.ColPulseSel))
                & activeConf.ColMask[NC*f +: NC] & {NC{activeConf.EnFlavor[f]}};
            expHitOr[f] = activeConf.EnHitOr[f] & (|hitIn);
            clearCol = '0;
            found = 1'b0;
            if (Read[f] && expToken[f]) begin
                if (activeConf.EnTestPattern[f]) begin
                    expValid[f] = 1'b1;
                    expWord[f]  = monopixPkg::TEST_PATTERN;
                end else begin
                    for (int c = 0; c < NC; c++) begin
                        if (fullBefore[c] && !found) begin  // Lowest column first
                            found       = 1'b1;
                            clearCol[c] = 1'b1;
                            expValid[f] = 1'b1;
                            expWord[f]  = {AW'(c), refBcid[f][c]};
                        end
                    end
                end
            end
            for (int c = 0; c < NC; c++) begin
                if (hitIn[c] && !fullBefore[c] && !refFrozen[f]) begin
                    refFull[f][c] = 1'b1;
                    refBcid[f][c] = grayNow;
                end
            end
            refFull[f]  = refFull[f] & ~clearCol;
            expToken[f] = refFrozen[f] & (|fullBefore)
                & activeConf.EnFlavor[f] & activeConf.EnOut[f];
        end
        wordSeen  = wordSeen | expValid;
        refFrozen = Freeze;
        refBin    = ResetBcid ? '0 : refBin + 1'b1;
        if (reset_ff || DefConf) begin
            activeConf = monopixPkg::DEFAULT_CONF;
            refShadow  = monopixPkg::DEFAULT_CONF;
        end else begin
            if (ConfLoad) begin
                activeConf = monopixPkg::confT'(refShadow);  // Shadow before this shift
            end
            if (ConfShift) begin
                refShadow = {refShadow[CB-2:0], ConfSi};
            end
        end
        if (reset_ff) begin
            refBin    = '0;
            refFrozen = '0;
            refFull   = '0;
            expToken  = '0;
            expValid  = '0;
            expHitOr  = '0;
        end
        @(posedge ClkBx);
        @(negedge ClkBx);
        compareOutputs();
    endtask

    // Scan the old shadow out while the new word goes in and load it after
    task automatic shiftConf(input monopixPkg::confT newConf, input monopixPkg::confT expOld);
        logic [CB-1:0] scanned;
        for (int i = CB - 1; i >= 0; i--) begin
            scanned[i] = ConfSo;
            ConfShift  = 1'b1;
            ConfSi     = newConf[i];
            tick();
        end
        ConfShift = 1'b0;
        ConfSi    = 1'b0;
        assert (scanned === expOld) else reportMismatch("Scanned configuration", scanned, expOld);
        ConfLoad = 1'b1;
        tick();
        ConfLoad = 1'b0;
    endtask

    task automatic waitToken(input int f);
        int n;
        n = 0;
        while (Token[f] !== 1'b1 && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (Token[f] !== 1'b1) begin
            timeouts++;
            $display("Timeout: Token of flavor %0d did not rise within %0d cycles", f, TIMEOUT);
        end
    endtask

    task automatic readUntilEmpty(input int f);
        int n;
        n = 0;
        while (Token[f] === 1'b1 && n < TIMEOUT) begin
            Read[f] = 1'b1;
            tick();
            if (f % 2 == 0) begin  // Even flavors pause between reads
                Read[f] = 1'b0;
                tick();
            end
            n++;
        end
        Read[f] = 1'b0;
        if (Token[f] === 1'b1) begin
            timeouts++;
            $display("Timeout: Token of flavor %0d stayed high after %0d reads", f, TIMEOUT);
        end
    endtask

    // Freeze every flavor and read out whatever the model says is stored
    task automatic drainAll();
        Freeze = '1;
        tick();
        for (int f = 0; f < NF; f++) begin
            if (refFull[f] != '0 && activeConf.EnFlavor[f] && activeConf.EnOut[f]) begin
                waitToken(f);
                readUntilEmpty(f);
            end
        end
        Freeze = '0;
        tick();
    endtask

    initial begin
        monopixPkg::confT cfgMask;
        monopixPkg::confT cfgTest;
        monopixPkg::confT cfgPulse;
        reset_ff   = 1'b1;
        DefConf    = 1'b0;
        ConfShift  = 1'b0;
        ConfSi     = 1'b0;
        ConfLoad   = 1'b0;
        ResetBcid  = 1'b0;
        Pulse      = 1'b0;
        Hit        = '0;
        Freeze     = '0;
        Read       = '0;
        refShadow  = monopixPkg::DEFAULT_CONF;
        activeConf = monopixPkg::DEFAULT_CONF;
        refBcid    = '0;
        expWord    = '0;
        wordSeen   = '0;

        cfgMask = monopixPkg::DEFAULT_CONF;
        cfgMask.ColMask[2] = 1'b0;               // PMOS column 2
        cfgMask.ColMask[NC * COMPF + 5] = 1'b0;  // COMP column 5
        cfgTest = cfgMask;
        cfgTest.EnTestPattern[DPW] = 1'b1;
        cfgPulse = monopixPkg::DEFAULT_CONF;
        cfgPulse.EnFlavor    = 4'b1110;
        cfgPulse.EnHitOr     = 4'b0111;
        cfgPulse.EnOut       = 4'b1011;  // COMP output off
        cfgPulse.ColPulseSel = 8'h41;

        repeat (5) tick();
        reset_ff = 1'b0;
        tick();

        // Default scan-out followed by a masked setup written and read back
        shiftConf(cfgMask, monopixPkg::DEFAULT_CONF);
        shiftConf(cfgMask, cfgMask);

        // Random hits at known distances from ResetBcid
        ResetBcid = 1'b1;
        tick();
        ResetBcid = 1'b0;
        for (int k = 0; k < 6; k++) begin
            Hit = $random(seed) & $random(seed);
            if (k == 0) begin
                Hit = Hit | 32'h8080_8080 | 32'h0020_0004;  // Also hits masked columns
            end
            tick();
            Hit = '0;
            repeat (k + 1) tick();
        end
        Freeze = '1;
        tick();
        Hit = '1;  // Ignored while frozen
        tick();
        Hit = '0;
        drainAll();

        // Test pattern on PMOS_DPW keeps the stored hits
        shiftConf(cfgTest, cfgMask);
        Hit = $random(seed) | 32'h0000_0100;
        tick();
        Hit = '0;
        tick();
        Freeze[DPW] = 1'b1;
        tick();
        waitToken(DPW);
        repeat (3) begin
            Read[DPW] = 1'b1;
            tick();
            Read[DPW] = 1'b0;
            tick();
        end
        shiftConf(cfgMask, cfgTest);
        drainAll();

        // Injection with flavor, HitOr and output gating
        shiftConf(cfgPulse, cfgMask);
        Pulse = 1'b1;
        tick();
        Pulse = 1'b0;
        tick();
        drainAll();
        Freeze = '1;
        Read[COMPF] = 1'b1;
        repeat (4) tick();
        Read   = '0;
        Freeze = '0;
        tick();
        DefConf = 1'b1;
        tick();
        DefConf = 1'b0;
        drainAll();  // COMP words come out now
        repeat (3) tick();

        $display("Errors: %0d value, %0d property, %0d timeout", errors, propErrors, timeouts);
        if (errors == 0 && propErrors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- sources.f
common/monopixPkg.sv
common/colBusIf.sv
design/confShiftReg.sv
design/bcidCounter.sv
readout/pixelColumns.sv
readout/tokenReadout.sv
design/monopixTop.sv
verif/tbMonopix.sv

//--- Makefile
TOP = tbMonopix
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

obj_dir/V$(TOP): sources.f
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
